/* logic/lsu_pkg.sv */
package lsu_pkg;

	// ************************************************************************
	// executed instruction handed to the memory stage
	// ************************************************************************
	typedef struct packed {
		logic [3:0]  rd;
		logic [31:0] exu_val;    // alu result, also the memory address
		logic [31:0] csr_val;
		logic [31:0] store_data;
		logic [31:0] pc;
		logic [31:0] csr_jump;
		logic [2:0]  funct3;
		logic        mem_ren;
		logic        mem_wen;
		logic        reg_wen;
		logic        jal_enable;
		logic        csr_enable;
		logic        exu_jump_en;
		logic        csr_jump_en;
		logic [2:0]  spare;      // always zero
	} lsu_req_t;

	// retired instruction, also the writeback word
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] jump_addr;
		logic [31:0] wb_val;
		logic [3:0]  rd;
		logic        reg_wen;
	} retire_t;

	// ************************************************************************
	// axi-lite channel payloads
	// ************************************************************************
	typedef struct packed {
		logic [31:0] araddr;
		logic [2:0]  arsize;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] awaddr;
		logic [2:0]  awsize;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} axi_w_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axi_r_t;

	typedef struct packed {
		logic [1:0] bresp;
	} axi_b_t;

	// load/store width encodings
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

endpackage

/* logic/lsu_issue.sv */
`timescale 1ns/1ns

module lsu_issue #(
	parameter int ISSUE_DEPTH = 4
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              req_valid,
	input  lsu_pkg::lsu_req_t req,
	output logic              lsu_valid,
	output lsu_pkg::lsu_req_t lsu_req,
	input  logic              lsu_ready
);

	localparam int PTR_W = $clog2(ISSUE_DEPTH);
	localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

	lsu_pkg::lsu_req_t fifo [ISSUE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              push;
	logic              pop;
	logic              full;

	assign full      = (count == CNT_W'(ISSUE_DEPTH));
	assign push      = req_valid & ~full;
	assign pop       = lsu_valid & lsu_ready;
	assign lsu_valid = (count != '0);
	assign lsu_req   = fifo[rd_ptr]; // oldest entry

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			fifo[wr_ptr] <= req;
	end

	// caller keeps outstanding requests within the queue depth
	assert property (@(posedge clock) disable iff (reset) req_valid |-> !full);

	// empty queue has both pointers together
	assert property (@(posedge clock) disable iff (reset) !lsu_valid |-> rd_ptr == wr_ptr);

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ns

module lsu (
	input  logic              clock,
	input  logic              reset,
	input  logic              lsu_valid,
	input  lsu_pkg::lsu_req_t lsu_req,
	output logic              lsu_ready,
	output logic              arvalid,
	output lsu_pkg::axi_ar_t  ar,
	input  logic              arready,
	input  logic              rvalid,
	input  lsu_pkg::axi_r_t   r,
	output logic              rready,
	output logic              awvalid,
	output lsu_pkg::axi_aw_t  aw,
	input  logic              awready,
	output logic              wvalid,
	output lsu_pkg::axi_w_t   w,
	input  logic              wready,
	input  logic              bvalid,
	input  lsu_pkg::axi_b_t   b,
	output logic              bready,
	output logic              wb_valid,
	output lsu_pkg::retire_t  wb
);

	lsu_pkg::lsu_req_t req_q;
	logic              accept;
	logic [31:0]       snpc;
	logic [31:0]       load_shift;
	logic [31:0]       load_val;
	logic [3:0]        store_mask;

	assign accept = lsu_valid & lsu_ready;
	assign snpc   = lsu_req.pc + 32'd4;

	// ************************************************************************
	// handshake control
	// ************************************************************************
	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_ready <= 1'b1;
			arvalid   <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			wb_valid  <= 1'b0;
		end else begin
			wb_valid <= (accept & ~lsu_req.mem_ren & ~lsu_req.mem_wen)
				| (rvalid & rready) | (bvalid & bready);

			if (accept)
				lsu_ready <= 1'b0;
			else if (wb_valid)
				lsu_ready <= 1'b1; // back the cycle after writeback

			if (accept && lsu_req.mem_ren)
				arvalid <= 1'b1;
			else if (arready)
				arvalid <= 1'b0;

			if (accept && lsu_req.mem_wen)
				awvalid <= 1'b1;
			else if (awready)
				awvalid <= 1'b0;

			if (accept && lsu_req.mem_wen)
				wvalid <= 1'b1;
			else if (wready)
				wvalid <= 1'b0;
		end
	end

	// request latch and writeback selection
	always_ff @(posedge clock) begin
		if (accept) begin
			req_q        <= lsu_req;
			wb.pc        <= lsu_req.pc;
			wb.rd        <= lsu_req.rd;
			wb.reg_wen   <= lsu_req.reg_wen;
			wb.wb_val    <= lsu_req.jal_enable ? snpc :
				lsu_req.csr_enable ? lsu_req.csr_val : lsu_req.exu_val;
			wb.jump_addr <= lsu_req.csr_jump_en ? lsu_req.csr_jump :
				lsu_req.exu_jump_en ? lsu_req.exu_val : snpc;
		end else if (rvalid && rready) begin
			wb.wb_val <= load_val;
		end
	end

	// ************************************************************************
	// bus side
	// ************************************************************************
	assign rready    = 1'b1;
	assign bready    = 1'b1;
	assign ar.araddr = req_q.exu_val;
	assign ar.arsize = {1'b0, req_q.funct3[1:0]};
	assign aw.awaddr = req_q.exu_val;
	assign aw.awsize = {1'b0, req_q.funct3[1:0]};

	always_comb begin
		case (req_q.funct3)
			lsu_pkg::F3_B: store_mask = 4'b0001;
			lsu_pkg::F3_H: store_mask = 4'b0011;
			lsu_pkg::F3_W: store_mask = 4'b1111;
			default:       store_mask = 4'b0000;
		endcase
	end

	assign w.wstrb = store_mask << req_q.exu_val[1:0];
	assign w.wdata = req_q.store_data << {req_q.exu_val[1:0], 3'b000};

	// load extension
	assign load_shift = r.rdata >> {req_q.exu_val[1:0], 3'b000};

	always_comb begin
		case (req_q.funct3)
			lsu_pkg::F3_B:  load_val = {{24{load_shift[7]}}, load_shift[7:0]};
			lsu_pkg::F3_H:  load_val = {{16{load_shift[15]}}, load_shift[15:0]};
			lsu_pkg::F3_W:  load_val = load_shift;
			lsu_pkg::F3_BU: load_val = {24'd0, load_shift[7:0]};
			lsu_pkg::F3_HU: load_val = {16'd0, load_shift[15:0]};
			default:        load_val = 32'd0;
		endcase
	end

	// only naturally aligned accesses reach the bus
	assert property (@(posedge clock) disable iff (reset)
		accept && (lsu_req.mem_ren || lsu_req.mem_wen) |->
			(lsu_req.funct3[1:0] == 2'b00) ||
			(lsu_req.funct3[1:0] == 2'b01 && lsu_req.exu_val[0] == 1'b0) ||
			(lsu_req.funct3[1:0] == 2'b10 && lsu_req.exu_val[1:0] == 2'b00));

	assert property (@(posedge clock) disable iff (reset)
		accept |-> !(lsu_req.mem_ren && lsu_req.mem_wen));

	// no error responses from the sram
	assert property (@(posedge clock) disable iff (reset)
		!(rvalid && r.rresp != 2'b00) && !(bvalid && b.bresp != 2'b00));

endmodule

/* logic/axi_sram.sv */
`timescale 1ns/1ns

module axi_sram #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             arvalid,
	input  lsu_pkg::axi_ar_t ar,
	output logic             arready,
	output logic             rvalid,
	output lsu_pkg::axi_r_t  r,
	input  logic             rready,
	input  logic             awvalid,
	input  lsu_pkg::axi_aw_t aw,
	output logic             awready,
	input  logic             wvalid,
	input  lsu_pkg::axi_w_t  w,
	output logic             wready,
	output logic             bvalid,
	output lsu_pkg::axi_b_t  b,
	input  logic             bready
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [31:0]      mem [MEM_WORDS] = '{default: '0};
	logic             busy;
	logic             is_write;
	logic [CNT_W-1:0] cnt;
	logic [31:0]      rdata_q;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic             rd_go;
	logic             wr_go;

	// word index wraps at the array size
	assign rd_idx = IDX_W'((ar.araddr >> 2) % MEM_WORDS);
	assign wr_idx = IDX_W'((aw.awaddr >> 2) % MEM_WORDS);

	assign arready = ~busy;
	assign rd_go   = arvalid & arready;
	assign wr_go   = ~busy & awvalid & wvalid & ~arvalid; // reads win
	assign awready = wr_go;
	assign wready  = wr_go;

	assign rvalid  = busy & ~is_write & (cnt == '0);
	assign bvalid  = busy & is_write & (cnt == '0);
	assign r.rdata = rdata_q;
	assign r.rresp = 2'b00;
	assign b.bresp = 2'b00;

	// ************************************************************************
	// one transaction at a time, fixed latency
	// ************************************************************************
	always_ff @(posedge clock) begin
		if (reset) begin
			busy     <= 1'b0;
			is_write <= 1'b0;
			cnt      <= '0;
		end else if (rd_go || wr_go) begin
			busy     <= 1'b1;
			is_write <= wr_go;
			cnt      <= CNT_W'(MEM_LATENCY - 1);
		end else if (busy) begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else if ((rvalid && rready) || (bvalid && bready))
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_go)
			rdata_q <= mem[rd_idx];
		if (wr_go) begin
			for (int i = 0; i < 4; i++) begin
				if (w.wstrb[i])
					mem[wr_idx][8*i +: 8] <= w.wdata[8*i +: 8];
			end
		end
	end

	// strobes agree with the access size from the master
	assert property (@(posedge clock) disable iff (reset)
		wr_go |-> $countones(w.wstrb) == (1 << aw.awsize));

	assert property (@(posedge clock) disable iff (reset)
		rd_go |-> (ar.araddr & ((32'd1 << ar.arsize) - 32'd1)) == 32'd0);

endmodule

/* logic/lsu_regfile.sv */
`timescale 1ns/1ns

module lsu_regfile (
	input  logic             clock,
	input  logic             reset,
	input  logic             wb_valid,
	input  lsu_pkg::retire_t wb,
	output logic             retire_valid,
	output lsu_pkg::retire_t retire,
	input  logic [3:0]       rs_addr,
	output logic [31:0]      rs_data
);

	logic [31:0] regs [16];
	logic        do_write;

	assign do_write = wb_valid & wb.reg_wen & (wb.rd != 4'd0); // x0 never written

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 32'd0;
			end
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= wb_valid;
			if (do_write)
				regs[wb.rd] <= wb.wb_val;
		end
	end

	// retire announcement
	always_ff @(posedge clock) begin
		if (wb_valid)
			retire <= wb;
	end

	// decode read port
	assign rs_data = (rs_addr == 4'd0) ? 32'd0 : regs[rs_addr];

endmodule

/* logic/lsu_sys.sv */
`timescale 1ns/1ns

module lsu_sys #(
	parameter int ISSUE_DEPTH = 4,
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              req_valid,
	input  lsu_pkg::lsu_req_t req,
	output logic              retire_valid,
	output lsu_pkg::retire_t  retire,
	input  logic [3:0]        rs_addr,
	output logic [31:0]       rs_data
);

	logic              lsu_valid;
	lsu_pkg::lsu_req_t lsu_req;
	logic              lsu_ready;
	logic              arvalid;
	lsu_pkg::axi_ar_t  ar;
	logic              arready;
	logic              rvalid;
	lsu_pkg::axi_r_t   r;
	logic              rready;
	logic              awvalid;
	lsu_pkg::axi_aw_t  aw;
	logic              awready;
	logic              wvalid;
	lsu_pkg::axi_w_t   w;
	logic              wready;
	logic              bvalid;
	lsu_pkg::axi_b_t   b;
	logic              bready;
	logic              wb_valid;
	lsu_pkg::retire_t  wb;

	lsu_issue #(.ISSUE_DEPTH(ISSUE_DEPTH)) i_lsu_issue (
		.clock, .reset, .req_valid, .req, .lsu_valid, .lsu_req, .lsu_ready
	);

	lsu i_lsu (
		.clock, .reset, .lsu_valid, .lsu_req, .lsu_ready,
		.arvalid, .ar, .arready, .rvalid, .r, .rready,
		.awvalid, .aw, .awready, .wvalid, .w, .wready,
		.bvalid, .b, .bready, .wb_valid, .wb
	);

	axi_sram #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) i_axi_sram (
		.clock, .reset, .arvalid, .ar, .arready, .rvalid, .r, .rready,
		.awvalid, .aw, .awready, .wvalid, .w, .wready, .bvalid, .b, .bready
	);

	lsu_regfile i_lsu_regfile (
		.clock, .reset, .wb_valid, .wb, .retire_valid, .retire, .rs_addr, .rs_data
	);

endmodule

/* verif/lsu_model.svh */
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// ****************************************************************************
// reference model, byte memory mirror and register mirror
// ****************************************************************************
logic [7:0]       mem_model [MEM_WORDS*4] = '{default: '0};
logic [31:0]      reg_model [16] = '{default: '0};
lsu_pkg::retire_t expected [$]; // predicted retires in issue order

function automatic int access_bytes(input logic [2:0] f3);
	case (f3)
		lsu_pkg::F3_B, lsu_pkg::F3_BU: return 1;
		lsu_pkg::F3_H, lsu_pkg::F3_HU: return 2;
		default:                       return 4;
	endcase
endfunction

// little endian gather, top byte first
function automatic logic [31:0] read_bytes(input logic [31:0] addr, input int n, input logic sext);
	logic [31:0] v;
	v = '0;
	for (int i = n - 1; i >= 0; i--)
		v = {v[23:0], mem_model[addr+i]};
	if (sext && n < 4 && v[8*n-1])
		v = v | (32'hffff_ffff << (8 * n));
	return v;
endfunction

function automatic lsu_pkg::retire_t predict(input lsu_pkg::lsu_req_t q);
	lsu_pkg::retire_t p;
	logic [31:0]      link;
	int               n;
	link        = q.pc + 32'd4;
	n           = access_bytes(q.funct3);
	p.pc        = q.pc;
	p.rd        = q.rd;
	p.reg_wen   = q.reg_wen;
	p.jump_addr = q.csr_jump_en ? q.csr_jump : (q.exu_jump_en ? q.exu_val : link);
	if (q.mem_ren)
		p.wb_val = read_bytes(q.exu_val, n,
			q.funct3 == lsu_pkg::F3_B || q.funct3 == lsu_pkg::F3_H);
	else
		p.wb_val = q.jal_enable ? link : (q.csr_enable ? q.csr_val : q.exu_val);
	if (q.mem_wen) begin
		for (int i = 0; i < n; i++)
			mem_model[q.exu_val+i] = q.store_data[8*i +: 8];
	end
	if (q.reg_wen && q.rd != 4'd0)
		reg_model[q.rd] = p.wb_val; // x0 stays zero
	return p;
endfunction

`endif

/* verif/lsu_sys_tb.sv */
`timescale 1ns/1ns

module lsu_sys_tb;

	localparam int ISSUE_DEPTH = 4;
	localparam int MEM_WORDS   = 256;
	localparam int MEM_LATENCY = 2;
	localparam int OPS_TOTAL   = 40 + 56 + 150 + 41 + 40 + 300; // per test, in run order
	localparam longint WATCHDOG_NS =
		longint'(OPS_TOTAL) * (ISSUE_DEPTH + 1) * (2 * MEM_LATENCY + 6) * 100;
	localparam logic [2:0] LOAD_F3 [5] = '{lsu_pkg::F3_B, lsu_pkg::F3_H, lsu_pkg::F3_W,
		lsu_pkg::F3_BU, lsu_pkg::F3_HU};
	localparam logic [2:0] STORE_F3 [3] = '{lsu_pkg::F3_B, lsu_pkg::F3_H, lsu_pkg::F3_W};

	logic              clock = 1'b0;
	logic              reset;
	logic              req_valid;
	lsu_pkg::lsu_req_t req;
	logic              retire_valid;
	lsu_pkg::retire_t  retire;
	logic [3:0]        rs_addr;
	logic [31:0]       rs_data;
	logic [31:0]       lfsr = 32'he975f065;
	logic [31:0]       word_addr [24];
	string             test_name;
	int                issued;
	int                retired;
	int                outstanding;
	int                checks;
	int                errors;
	int                errors_before;
	int                tests;

	`include "lsu_model.svh"

	lsu_sys #(.ISSUE_DEPTH(ISSUE_DEPTH), .MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY))
		i_lsu_sys (.clock, .reset, .req_valid, .req, .retire_valid, .retire, .rs_addr, .rs_data);

	always #50 clock = ~clock;

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	// kind 0 alu, 1 jal, 2 csr, 3 load, 4 store
	function automatic lsu_pkg::lsu_req_t make_op(input int kind, input logic [2:0] f3,
		input logic [31:0] addr);
		lsu_pkg::lsu_req_t q;
		q.rd          = 4'(rand_bits(4));
		q.exu_val     = (kind >= 3) ? addr : rand_bits(32);
		q.csr_val     = rand_bits(32);
		q.store_data  = rand_bits(32);
		q.pc          = rand_bits(30) << 2;
		q.csr_jump    = rand_bits(32);
		q.funct3      = (kind >= 3) ? f3 : 3'(rand_bits(3));
		q.mem_ren     = (kind == 3);
		q.mem_wen     = (kind == 4);
		q.reg_wen     = (kind != 4);
		q.jal_enable  = (kind == 1);
		q.csr_enable  = (kind == 2) || (kind == 1 && rand_bits(1) != 0); // jal must still win
		q.exu_jump_en = 1'(rand_bits(1));
		q.csr_jump_en = 1'(rand_bits(1));
		q.spare       = '0;
		return q;
	endfunction

	function automatic lsu_pkg::lsu_req_t random_op(input int kind);
		logic [2:0]  f3;
		logic [31:0] offset;
		f3     = (kind == 4) ? STORE_F3[rand_bits(2) % 3] : LOAD_F3[rand_bits(3) % 5];
		offset = rand_bits(2) & (32'd4 - 32'(access_bytes(f3))); // aligned lanes only
		return make_op(kind, f3, (rand_bits(16) % MEM_WORDS) * 4 + offset);
	endfunction

	task automatic compare_retire(input lsu_pkg::retire_t exp, input lsu_pkg::retire_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic compare_word(input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	// ************************************************************************
	// falling edge, strobe cleared, retire sampled
	// ************************************************************************
	task automatic next_cycle();
		@(negedge clock);
		req_valid = 1'b0;
		if (retire_valid) begin
			retired++;
			outstanding--;
			if (expected.size() == 0) begin
				errors++;
				$display("%s: an instruction retired that was never issued", test_name);
			end else
				compare_retire(expected.pop_front(), retire);
		end
	endtask

	task automatic issue(input lsu_pkg::lsu_req_t q);
		next_cycle();
		while (outstanding >= ISSUE_DEPTH)
			next_cycle();
		req_valid = 1'b1;
		req       = q;
		expected.push_back(predict(q));
		issued++;
		outstanding++;
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		issued        = 0;
		retired       = 0;
		errors_before = errors;
	endtask

	task automatic finish_test();
		while (outstanding > 0)
			next_cycle();
		repeat (2 * MEM_LATENCY + 6) next_cycle(); // catch stray retires
		if (retired != issued) begin
			errors++;
			$display("%s: %0d instructions issued but %0d retired", test_name, issued, retired);
		end
		tests++;
		$display("test %s done: %0d issued, %0d retired, %0d errors", test_name, issued,
			retired, errors - errors_before);
	endtask

	initial begin
		lsu_pkg::lsu_req_t zero_op;
		logic [31:0]       base;
		logic [31:0]       addr;
		logic [2:0]        f3;
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		rs_addr   = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		start_test("nonmem");
		repeat (40) issue(random_op(rand_bits(2) % 3));
		finish_test();

		start_test("word_mem");
		for (int i = 0; i < 24; i++) begin
			word_addr[i] = (rand_bits(16) % (MEM_WORDS / 2)) * 4; // lower half
			issue(make_op(4, lsu_pkg::F3_W, word_addr[i]));
		end
		for (int i = 0; i < 24; i++)
			issue(make_op(3, lsu_pkg::F3_W, word_addr[i]));
		repeat (8) issue(make_op(3, lsu_pkg::F3_W,
			(MEM_WORDS / 2 + rand_bits(16) % (MEM_WORDS / 2)) * 4)); // never written
		finish_test();

		start_test("subword");
		repeat (6) begin
			base = (rand_bits(16) % MEM_WORDS) * 4;
			issue(make_op(4, lsu_pkg::F3_W, base));
			for (int o = 0; o < 6; o++) begin
				f3   = (o < 4) ? lsu_pkg::F3_B : lsu_pkg::F3_H;
				addr = base + ((o < 4) ? o : 2 * (o - 4));
				issue(make_op(4, f3, addr));
				issue(make_op(3, lsu_pkg::F3_W, base)); // neighbours untouched
				issue(make_op(3, f3, addr));
				issue(make_op(3, f3 | 3'b100, addr)); // unsigned twin
			end
		end
		finish_test();

		start_test("regfile");
		repeat (24) issue(random_op(rand_bits(2) % 3));
		zero_op         = make_op(0, 3'd0, 32'd0);
		zero_op.rd      = 4'd0;
		zero_op.reg_wen = 1'b1;
		zero_op.exu_val = 32'hdead_beef;
		issue(zero_op);
		while (outstanding > 0)
			next_cycle();
		for (int a = 0; a < 16; a++) begin
			rs_addr = 4'(a);
			next_cycle();
			compare_word(reg_model[a], rs_data);
		end
		finish_test();

		start_test("pressure");
		repeat (40) issue(random_op(rand_bits(3) % 5));
		finish_test();

		start_test("mixed");
		repeat (300) issue(random_op(rand_bits(3) % 5));
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout in test %s with %0d instructions not retired", test_name, outstanding);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* lsu_sys.f */
+incdir+verif
logic/lsu_pkg.sv
logic/lsu_issue.sv
logic/lsu.sv
logic/axi_sram.sv
logic/lsu_regfile.sv
logic/lsu_sys.sv
verif/lsu_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the lsu_sys testbench with verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module lsu_sys_tb -f lsu_sys.f -Mdir "$OBJ_DIR" -o lsu_sys_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$OBJ_DIR/lsu_sys_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
